/* data_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module data_packer #(
  parameter int vec_len = softmax_pkg::default_vec_len
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 empty,       // upstream fifo empty, fwft
  input  softmax_pkg::word_t   data_in,     // head word, valid while !empty
  input  logic                 stall,       // serializer still holds words
  output logic                 enable,      // pop strobe to upstream fifo
  output logic                 pack_valid,  // one-cycle, vector complete
  output logic [vec_len*8-1:0] pack_data    // logit i at bits 8i+:8
);
  import softmax_pkg::*;

  localparam int word_w = $bits(word_t);
  localparam int words  = vec_len / 2;       // two logits per word
  localparam int cnt_w  = $clog2(words + 1);

  logic [cnt_w-1:0] count;  // words taken for this vector
  logic             take;   // word accepted at this edge

  // skip the cycle after a pop, fwft head not yet updated
  assign take = !empty && !stall && !enable && (count < cnt_w'(words));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count      <= '0;
      enable     <= 1'b0;
      pack_valid <= 1'b0;
    end else begin
      pack_valid <= 1'b0;
      enable     <= take;           // pop lasts exactly one cycle
      if (count == cnt_w'(words)) begin
        pack_valid <= 1'b1;         // cycle after the last word
        count      <= '0;
      end else if (take) begin
        count <= count + 1'b1;
      end
    end
  end

  // new word enters at the top, so word 0 ends up in the low bits
  always_ff @(posedge clk) begin
    if (take) begin
      pack_data <= {data_in, pack_data[vec_len*8-1:word_w]};
    end
  end

endmodule

`default_nettype wire

/* expu.sv */
`timescale 1ns/1ps
`default_nettype none

module expu (
  input  softmax_pkg::logit_t y,      // sq3.4
  input  softmax_pkg::ln_t    ln_f,   // sq4.4, subtracted from y
  output softmax_pkg::exp_t   exp_y   // uq12.8, saturating
);
  import softmax_pkg::*;

  localparam int         exp_w = $bits(exp_t);
  localparam int         sc_w  = 32;      // mant << 22 still fits
  localparam logic [8:0] slope = 9'd11;   // ln2 in 1/16 steps, q0.8

  logic signed [8:0] diff;     // y - ln_f, no overflow in 9 bits
  logic signed [9:0] a;
  logic signed [9:0] m;        // a * log2(e), approx 1.4375
  logic signed [5:0] u;        // integer power of two
  logic        [3:0] v;        // fraction of the power
  logic        [8:0] mant;     // 2^v, linear fit, q1.8
  logic        [5:0] shamt;    // |u|
  logic   [sc_w-1:0] scaled;

  assign diff = {y[7], y} - {ln_f[7], ln_f};
  assign a    = {diff[8], diff};
  assign m    = a + (a >>> 1) - (a >>> 4);   // 1 + 1/2 - 1/16
  assign u    = m[9:4];
  assign v    = m[3:0];
  assign mant = 9'd256 + v * slope;          // max 421

  assign shamt  = u[5] ? -u : u;
  assign scaled = u[5] ? ({{(sc_w-9){1'b0}}, mant} >> shamt)
                       : ({{(sc_w-9){1'b0}}, mant} << shamt);

  // clamp to all ones when anything spills past uq12.8
  always_comb begin
    if (|scaled[sc_w-1:exp_w]) begin
      exp_y = '1;
    end else begin
      exp_y = scaled[exp_w-1:0];
    end
  end

endmodule

`default_nettype wire

/* lnu.sv */
`timescale 1ns/1ps
`default_nettype none

module lnu (
  input  softmax_pkg::sum_t f,     // uq16.8 exponent sum
  output softmax_pkg::ln_t  ln_f   // sq4.4 natural log estimate
);
  import softmax_pkg::*;

  logic        [4:0]  z;        // leading zeros, 24 for f == 0
  logic signed [4:0]  w;        // floor(log2 f), -9..15
  sum_t               k;        // f normalised, leading one at msb
  logic signed [27:0] a;        // log2 f as sq5.23
  logic signed [27:0] scaled;   // a * 11/16, approx ln2
  logic signed [27:0] sh;       // back to 4 fraction bits

  // leading one detector, highest set bit wins
  always_comb begin
    z = 5'd24;
    for (int i = 0; i < 24; i++) begin
      if (f[i]) begin
        z = 5'(23 - i);
      end
    end
  end

  // modulo-32 subtract gives the right two's complement bits
  assign w = 5'd15 - z;
  assign k = f << z;

  // mantissa bits after the leading one act as the log fraction
  assign a      = {w, k[22:0]};
  assign scaled = (a >>> 1) + (a >>> 3) + (a >>> 4);
  assign sh     = scaled >>> 19;            // drop 19 of 23 frac bits

  always_comb begin
    if (sh > 28'sd127) begin
      ln_f = 8'sh7f;                        // large sums
    end else if (sh < -28'sd128) begin
      ln_f = 8'sh80;
    end else begin
      ln_f = sh[7:0];
    end
  end

endmodule

`default_nettype wire

/* result_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module result_serializer #(
  parameter int vec_len = softmax_pkg::default_vec_len
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 prob_valid,  // load a whole vector
  input  logic [vec_len*8-1:0] prob_data,
  input  logic                 tx_fifo_en,  // downstream read
  output softmax_pkg::word_t   tx_data,     // valid while !tx_empty
  output logic                 tx_empty,
  output logic                 stall        // holds off the packer
);
  import softmax_pkg::*;

  localparam int word_w = $bits(word_t);
  localparam int words  = vec_len / 2;
  localparam int idx_w  = $clog2(words);

  logic [vec_len*8-1:0] buffer;   // result vector being drained
  logic [idx_w-1:0]     idx;      // word currently presented
  logic                 pending;  // words left to send
  logic                 accept;
  logic                 last;

  assign accept = tx_fifo_en && pending;
  assign last   = (idx == idx_w'(words - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx     <= '0;
      pending <= 1'b0;
    end else if (prob_valid) begin
      idx     <= '0;        // restart at word 0
      pending <= 1'b1;
    end else if (accept) begin
      if (last) begin
        idx     <= '0;
        pending <= 1'b0;    // empty again after final read
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (prob_valid) begin
      buffer <= prob_data;
    end
  end

  // low byte is the even element, same as the packed layout
  assign tx_data  = buffer[idx*word_w +: word_w];
  assign stall    = pending;
  assign tx_empty = !pending;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_softmax -f softmax.f -o Vtb_softmax \
  && ./obj_dir/Vtb_softmax > softmax_sim.log 2>&1 \
  || { cat softmax_sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat softmax_sim.log
grep -q "test failed" softmax_sim.log && exit 1
grep -q "test passed" softmax_sim.log || exit 1
exit 0

/* softmax.f */
softmax_pkg.sv
data_packer.sv
expu.sv
lnu.sv
softmax_core.sv
result_serializer.sv
softmax_top.sv
softmax_assert.sv
tb_softmax.sv

/* softmax_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module softmax_assert (
  input logic clk,
  input logic rst_n,
  input logic enable,      // packer pop strobe
  input logic pack_valid,  // packer vector done
  input logic prob_valid,  // core result into the serializer
  input logic stall        // serializer pending
);

  // fwft head needs a cycle to update after a pop
  a_enable_gap : assert property (@(posedge clk) disable iff (!rst_n)
    enable |=> !enable)
    else $error("enable high in two consecutive cycles");

  a_pack_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    pack_valid |=> !pack_valid)
    else $error("pack_valid longer than one cycle");

  // packing time must outlast the drain, no vector overwritten
  a_load_idle : assert property (@(posedge clk) disable iff (!rst_n)
    prob_valid |-> !stall)
    else $error("result vector arrived while the serializer still held words");

endmodule

// packer side, serializer signals tied to their idle levels
bind data_packer softmax_assert packer_assert_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .enable     (enable),
  .pack_valid (pack_valid),
  .prob_valid (1'b0),
  .stall      (1'b0)
);

bind result_serializer softmax_assert serializer_assert_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .enable     (1'b0),
  .pack_valid (1'b0),
  .prob_valid (prob_valid),
  .stall      (stall)
);

`default_nettype wire

/* softmax_core.sv */
`timescale 1ns/1ps
`default_nettype none

module softmax_core #(
  parameter int vec_len = softmax_pkg::default_vec_len
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pack_valid,  // one-cycle, new vector
  input  logic [vec_len*8-1:0] pack_data,
  output logic                 prob_valid,  // 3 cycles after pack_valid
  output logic [vec_len*8-1:0] prob_data
);
  import softmax_pkg::*;

  localparam int tree_n = 1 << $clog2(vec_len);  // leaves, padded with zeros

  logit_t x_s1    [vec_len];  // stage one logits
  logit_t x_s2    [vec_len];  // travel alongside the sum
  exp_t   e1      [vec_len];  // exp(x)
  exp_t   e2      [vec_len];  // exp(x - ln sum)
  prob_t  p_clamp [vec_len];
  sum_t   sum_tree;           // comb, from stage one
  sum_t   sum_s2;
  ln_t    ln_sum;             // comb, from stage two
  logic   valid_s1;
  logic   valid_s2;

  for (genvar i = 0; i < vec_len; i++) begin : g_lane
    expu u_exp_num (
      .y     (x_s1[i]),
      .ln_f  ('0),         // plain exponent for the sum
      .exp_y (e1[i])
    );
    expu u_exp_out (
      .y     (x_s2[i]),
      .ln_f  (ln_sum),
      .exp_y (e2[i])
    );
  end

  lnu u_lnu (
    .f    (sum_s2),
    .ln_f (ln_sum)
  );

  // balanced adder tree, node 0 is the root
  always_comb begin : p_tree
    sum_t node [2*tree_n-1];
    for (int i = 0; i < tree_n; i++) begin
      node[tree_n-1+i] = '0;
    end
    for (int i = 0; i < vec_len; i++) begin
      node[tree_n-1+i] = sum_t'(e1[i]);
    end
    for (int j = tree_n - 2; j >= 0; j--) begin
      node[j] = node[2*j+1] + node[2*j+2];
    end
    sum_tree = node[0];
  end

  // 256 is 1.0 in uq12.8, saturate to ff
  always_comb begin
    for (int i = 0; i < vec_len; i++) begin
      p_clamp[i] = (|e2[i][19:8]) ? 8'hff : e2[i][7:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1   <= 1'b0;
      valid_s2   <= 1'b0;
      prob_valid <= 1'b0;
    end else begin
      valid_s1   <= pack_valid;
      valid_s2   <= valid_s1;
      prob_valid <= valid_s2;
    end
  end

  // each stage loads on its own valid, one vector per cycle possible
  always_ff @(posedge clk) begin
    if (pack_valid) begin
      for (int i = 0; i < vec_len; i++) begin
        x_s1[i] <= pack_data[8*i +: 8];
      end
    end
    if (valid_s1) begin
      sum_s2 <= sum_tree;
      x_s2   <= x_s1;
    end
    if (valid_s2) begin
      for (int i = 0; i < vec_len; i++) begin
        prob_data[8*i +: 8] <= p_clamp[i];
      end
    end
  end

endmodule

`default_nettype wire

/* softmax_pkg.sv */
`default_nettype none

package softmax_pkg;

  // one fifo word, two 8-bit lanes
  typedef logic [15:0] word_t;

  // sq3.4 input logit
  typedef logic signed [7:0] logit_t;

  // sq4.4 log of the exponent sum
  typedef logic signed [7:0] ln_t;

  // uq12.8 exponent, 1.0 = 256
  typedef logic [19:0] exp_t;

  // uq16.8, holds up to 16 saturated exponents
  typedef logic [23:0] sum_t;

  // uq0.8 output probability
  typedef logic [7:0] prob_t;

  // logits per vector unless the top overrides it
  localparam int default_vec_len = 8;

endpackage

`default_nettype wire

/* softmax_testdata.txt */
1 0000 0000 0000 0000 2121 2121 2121 2121
1 0030 1000 0000 00e0 0ac2 190a 0a0a 0a01
1 0010 0000 0000 0000 194d 1919 1919 1919
1 f020 f020 f020 f020 044d 044d 044d 044d
0 1234 abcd 0f0f beef 1234 abcd 0f0f beef
0 0001 8000 ffff 5a5a 0001 8000 ffff 5a5a
2 7f7f 7f7f 7f7f 7f7f ffff ffff ffff ffff
2 807f 8080 8080 8080 00ff 0000 0000 0000
3 8080 8080 8080 8080 2828 2828 2828 2828
0 c001 d00d 0000 7777 c001 d00d 0000 7777
1 0030 1000 0000 00e0 0ac2 190a 0a0a 0a01
1 0000 0000 0000 0000 2121 2121 2121 2121

/* softmax_top.sv */
`timescale 1ns/1ps
`default_nettype none

module softmax_top #(
  parameter int vec_len = softmax_pkg::default_vec_len
) (
  input  logic               clk,
  input  logic               rst_n,
  input  softmax_pkg::word_t fifo_data,   // upstream fwft fifo
  input  logic               fifo_empty,
  output logic               rd_en,
  output softmax_pkg::word_t tx_data,     // downstream port
  output logic               tx_empty,
  input  logic               tx_fifo_en,
  input  logic [1:0]         control      // 00 bypass, else softmax
);
  import softmax_pkg::*;

  logic                 bypass;
  logic                 pack_empty;   // packer sees nothing in bypass
  logic                 pack_rd_en;
  logic                 pack_valid;
  logic [vec_len*8-1:0] pack_data;
  logic                 prob_valid;
  logic [vec_len*8-1:0] prob_data;
  logic                 stall;
  logic                 ser_en;
  logic                 ser_empty;
  word_t                ser_data;

  // even, 6..16, see sum_t headroom and core latency
  if ((vec_len % 2) != 0 || vec_len < 6 || vec_len > 16) begin : g_bad_len
    $error("vec_len must be even and within 6..16");
  end

  assign bypass     = (control == 2'b00);
  assign pack_empty = fifo_empty | bypass;
  assign ser_en     = tx_fifo_en & ~bypass;

  data_packer #(.vec_len(vec_len)) u_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .empty      (pack_empty),
    .data_in    (fifo_data),
    .stall      (stall),
    .enable     (pack_rd_en),
    .pack_valid (pack_valid),
    .pack_data  (pack_data)
  );

  softmax_core #(.vec_len(vec_len)) u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .pack_valid (pack_valid),
    .pack_data  (pack_data),
    .prob_valid (prob_valid),
    .prob_data  (prob_data)
  );

  result_serializer #(.vec_len(vec_len)) u_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .prob_valid (prob_valid),
    .prob_data  (prob_data),
    .tx_fifo_en (ser_en),
    .tx_data    (ser_data),
    .tx_empty   (ser_empty),
    .stall      (stall)
  );

  // bypass hands the upstream fifo straight to the reader
  assign rd_en    = bypass ? tx_fifo_en : pack_rd_en;
  assign tx_data  = bypass ? fifo_data  : ser_data;
  assign tx_empty = bypass ? fifo_empty : ser_empty;

endmodule

`default_nettype wire

/* tb_softmax.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_softmax;
  import softmax_pkg::*;

  localparam int vec_len = default_vec_len;
  localparam int words   = vec_len / 2;   // four words per record in the data file
  localparam int max_rec = 64;

  logic       clk;
  logic       rst_n;
  word_t      fifo_data;
  logic       fifo_empty;
  logic       rd_en;
  word_t      tx_data;
  logic       tx_empty;
  logic       tx_fifo_en;
  logic [1:0] control;

  logic [1:0] rec_ctrl [max_rec];
  word_t      rec_in   [max_rec*words];
  word_t      rec_exp  [max_rec*words];
  int         n_rec;

  word_t      up_q[$];      // upstream fwft fifo, head at index 0
  word_t      exp_q[$];     // result words still owed by the dut
  logic [1:0] mode;         // control value for the next falling edge
  logic       pop_pending;  // rd_en seen, pop happens at the rising edge
  int         pops;
  int         takes;
  int         errors;
  int         checked;
  int         seed;
  int         cycle_count;
  int         cycle_limit;

  softmax_top #(.vec_len(vec_len)) softmax_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .rd_en      (rd_en),
    .tx_data    (tx_data),
    .tx_empty   (tx_empty),
    .tx_fifo_en (tx_fifo_en),
    .control    (control)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] want);
    if (got !== want) begin
      errors++;
      $display("Fail %s: got %h, expected %h at cycle %0d", name, got, want, cycle_count);
    end
  endtask

  // one record per line: control, four input words, four expected words
  task automatic load_records();
    int    fd;
    int    code;
    word_t fld [9];
    fd = $fopen("softmax_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open softmax_testdata.txt");
    end else begin
      code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h\n", fld[0], fld[1], fld[2], fld[3],
                     fld[4], fld[5], fld[6], fld[7], fld[8]);
      while (code == 9 && n_rec < max_rec) begin
        rec_ctrl[n_rec] = fld[0][1:0];
        for (int k = 0; k < words; k++) begin
          rec_in[n_rec*words+k]  = fld[1+k];
          rec_exp[n_rec*words+k] = fld[5+k];
        end
        n_rec++;
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h\n", fld[0], fld[1], fld[2], fld[3],
                       fld[4], fld[5], fld[6], fld[7], fld[8]);
      end
      $fclose(fd);
    end
  endtask

  // word read by the downstream side at the coming rising edge
  task automatic take_word(input word_t got);
    word_t want;
    if (exp_q.size() == 0) begin
      errors++;
      $display("extra word %h came out of tx_data with no result pending", got);
    end else begin
      want = exp_q.pop_front();
      compare("tx_data", got, want);
      checked++;
    end
    takes++;
    if (control != 2'b00 && takes > (pops / words) * words) begin
      errors++;
      $display("result word left before its whole input vector was read upstream");
    end
  endtask

  // falling edge drive, then look at settled outputs 1 ns later
  task automatic step();
    int rnd;
    @(negedge clk);
    if (pop_pending && up_q.size() > 0) begin
      void'(up_q.pop_front());
    end
    control    = mode;
    fifo_empty = (up_q.size() == 0);
    fifo_data  = fifo_empty ? 16'h0000 : up_q[0];
    rnd        = $random(seed);
    tx_fifo_en = rnd[0];                  // random gaps on the reader side
    #1;
    pop_pending = rd_en && !fifo_empty;
    if (pop_pending) begin
      pops++;
    end
    if (tx_fifo_en && !tx_empty) begin
      take_word(tx_data);
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    @(posedge rst_n);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d result words never arrived",
             cycle_count, exp_q.size());
    $display("errors: %0d, words checked: %0d", errors, checked);
    $display("test failed");
    $finish;
  end

  initial begin : main
    int         r;
    logic [1:0] grp;
    seed        = 45;
    errors      = 0;
    checked     = 0;
    n_rec       = 0;
    pops        = 0;
    takes       = 0;
    pop_pending = 1'b0;
    mode        = 2'b01;
    rst_n       = 1'b0;
    fifo_data   = 16'h0000;
    fifo_empty  = 1'b1;
    tx_fifo_en  = 1'b0;
    control     = 2'b01;                  // softmax mode, idle
    load_records();
    if (n_rec == 0) begin
      errors++;
      $display("no records read from softmax_testdata.txt");
    end
    cycle_limit = 400 * n_rec + 100;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    compare("tx_empty", tx_empty, 1'b1);
    repeat (10) begin                     // nothing upstream, nothing out
      step();
      compare("tx_empty", tx_empty, 1'b1);
      compare("rd_en", rd_en, 1'b0);
    end
    r = 0;
    while (r < n_rec) begin
      grp  = rec_ctrl[r];
      mode = grp;                         // control only changes while idle
      while (r < n_rec && rec_ctrl[r] == grp) begin
        for (int k = 0; k < words; k++) begin
          up_q.push_back(rec_in[r*words+k]);
          exp_q.push_back(rec_exp[r*words+k]);
        end
        r++;
      end
      pops  = 0;
      takes = 0;
      while (exp_q.size() > 0) begin
        step();
      end
      step();                             // retire the last pop, catch duplicates
    end
    $display("errors: %0d, words checked: %0d", errors, checked);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
